//--- common/sample_chain_defs.svh
`ifndef SAMPLE_CHAIN_DEFS_SVH
`define SAMPLE_CHAIN_DEFS_SVH

// Sample widths
`define SC_IN_WIDTH      12
`define SC_OUT_WIDTH     8

// Gain is signed fixed point, 256 is unity
`define SC_GAIN_WIDTH    16
`define SC_GAIN_RADIX    8

`define SC_OFFSET_WIDTH  10 // In output units

// Channels
`define SC_NUM_CHAN      4
`define SC_CHAN_WIDTH    2

// Cycles through gain_offset_clamp
`define SC_GOC_LATENCY   4

`endif

//--- common/sample_pkg.sv
`include "sample_chain_defs.svh"

package sample_pkg;

    // Channel tag
    typedef logic [`SC_CHAN_WIDTH-1:0] chan_t;

    // Raw sample into the chain
    typedef struct packed {
        chan_t                           chan;
        logic signed [`SC_IN_WIDTH-1:0]  data;
    } in_sample_t;

    // Conditioned sample out of the chain
    typedef struct packed {
        chan_t                           chan;
        logic signed [`SC_OUT_WIDTH-1:0] data;
    } out_sample_t;

endpackage

//--- common/calib_pkg.sv
`include "sample_chain_defs.svh"

package calib_pkg;

    import sample_pkg::*;

    // Per-channel coefficients
    typedef struct packed {
        logic signed [`SC_GAIN_WIDTH-1:0]   gain;   // Q.GAIN_RADIX
        logic signed [`SC_OFFSET_WIDTH-1:0] offset;
    } coef_t;

    // Configuration write
    typedef struct packed {
        chan_t chan;
        coef_t coef;
    } cfg_write_t;

endpackage

//--- source/calib_stage.sv
`timescale 1ns/1ns
`include "sample_chain_defs.svh"

module calib_stage
    import sample_pkg::*;
    import calib_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,

    input  logic       cfg_wr,
    input  cfg_write_t cfg,

    input  logic       in_valid,
    input  in_sample_t in_sample,

    output logic       cal_valid,
    output in_sample_t cal_sample,
    output coef_t      cal_coef
);

    localparam logic signed [`SC_GAIN_WIDTH-1:0] UNITY_GAIN =
        {{(`SC_GAIN_WIDTH-`SC_GAIN_RADIX-1){1'b0}}, 1'b1, {`SC_GAIN_RADIX{1'b0}}};

    coef_t coef_mem [`SC_NUM_CHAN];

    // Coefficient bank
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `SC_NUM_CHAN; i++) begin
                coef_mem[i].gain   <= UNITY_GAIN;
                coef_mem[i].offset <= '0;
            end
        end else if (cfg_wr) begin
            coef_mem[cfg.chan] <= cfg.coef;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cal_valid <= 1'b0;
        end else begin
            cal_valid <= in_valid;
        end
    end

    // Old coefficients win when a write lands on the same edge
    always_ff @(posedge clk) begin
        cal_sample <= in_sample;
        cal_coef   <= coef_mem[in_sample.chan];
    end

    // Tags index the bank, so X here poisons the lookup
    in_sample_known_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        in_valid |-> !$isunknown(in_sample)
    );

endmodule

//--- gain_offset_clamp/gain_offset_clamp.sv
`timescale 1ns/1ns
`include "sample_chain_defs.svh"

module gain_offset_clamp #(
    parameter int IN_WIDTH     = `SC_IN_WIDTH,
    parameter int GAIN_WIDTH   = `SC_GAIN_WIDTH,
    parameter int GAIN_RADIX   = `SC_GAIN_RADIX,
    parameter int OFFSET_WIDTH = `SC_OFFSET_WIDTH,
    parameter int OUT_WIDTH    = `SC_OUT_WIDTH
) (
    input  logic                           clk,
    input  logic                           arst_n,

    input  logic                           in_valid,
    input  logic signed [IN_WIDTH-1:0]     in,
    input  logic signed [GAIN_WIDTH-1:0]   gain,
    input  logic signed [OFFSET_WIDTH-1:0] offset,

    output logic                           out_valid,
    output logic signed [OUT_WIDTH-1:0]    out
);

    localparam int PROD_W  = IN_WIDTH + GAIN_WIDTH;
    localparam int SUM_W   = PROD_W + 1;          // Headroom for the offset add
    localparam int SHIFT_W = SUM_W - GAIN_RADIX;

    localparam logic signed [SHIFT_W-1:0] OUT_MAX = SHIFT_W'((2 ** (OUT_WIDTH - 1)) - 1);
    localparam logic signed [SHIFT_W-1:0] OUT_MIN = -OUT_MAX - 1;

    logic                           valid_d1, valid_d2, valid_d3;
    logic signed [IN_WIDTH-1:0]     in_d1;
    logic signed [GAIN_WIDTH-1:0]   gain_d1;
    logic signed [OFFSET_WIDTH-1:0] offset_d1, offset_d2;
    logic signed [PROD_W-1:0]       product_d2;
    logic signed [SUM_W-1:0]        offset_scaled;
    logic signed [SUM_W-1:0]        sum_d3;
    logic signed [SHIFT_W-1:0]      shifted;
    logic signed [OUT_WIDTH-1:0]    out_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_d1  <= 1'b0;
            valid_d2  <= 1'b0;
            valid_d3  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_d1  <= in_valid;
            valid_d2  <= valid_d1;
            valid_d3  <= valid_d2;
            out_valid <= valid_d3;
        end
    end

    // Offset moved onto the gain radix
    assign offset_scaled = SUM_W'(offset_d2) <<< GAIN_RADIX;

    // Dropping the fraction bits gives floor
    assign shifted = sum_d3[SUM_W-1:GAIN_RADIX];

    always_ff @(posedge clk) begin
        in_d1      <= in;                    // Stage 1
        gain_d1    <= gain;
        offset_d1  <= offset;
        product_d2 <= in_d1 * gain_d1;       // Stage 2
        offset_d2  <= offset_d1;
        sum_d3     <= SUM_W'(product_d2) + offset_scaled; // Stage 3
        if (shifted > OUT_MAX) begin         // Stage 4
            out_q <= OUT_MAX[OUT_WIDTH-1:0];
        end else if (shifted < OUT_MIN) begin
            out_q <= OUT_MIN[OUT_WIDTH-1:0];
        end else begin
            out_q <= shifted[OUT_WIDTH-1:0];
        end
    end

    assign out = out_q;

    out_valid_known_a: assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(out_valid)
    );

    // Unsaturated value rebuilt from the operands four cycles back
    sat_high_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid
        && (((SUM_W'($past(in, 4)) * SUM_W'($past(gain, 4))
              + (SUM_W'($past(offset, 4)) <<< GAIN_RADIX)) >>> GAIN_RADIX) > OUT_MAX)
        |-> out == OUT_MAX[OUT_WIDTH-1:0]
    );
    sat_low_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid
        && (((SUM_W'($past(in, 4)) * SUM_W'($past(gain, 4))
              + (SUM_W'($past(offset, 4)) <<< GAIN_RADIX)) >>> GAIN_RADIX) < OUT_MIN)
        |-> out == OUT_MIN[OUT_WIDTH-1:0]
    );

endmodule

//--- source/tag_delay.sv
`timescale 1ns/1ns
`include "sample_chain_defs.svh"

module tag_delay
    import sample_pkg::*;
#(
    parameter int DEPTH = `SC_GOC_LATENCY
) (
    input  logic  clk,
    input  chan_t chan_in,
    output chan_t chan_out
);

    chan_t stage_q [DEPTH];

    // Runs every cycle so tags stay in step with the valid chain
    always_ff @(posedge clk) begin
        stage_q[0] <= chan_in;
        for (int i = 1; i < DEPTH; i++) begin
            stage_q[i] <= stage_q[i-1];
        end
    end

    assign chan_out = stage_q[DEPTH-1];

endmodule

//--- source/sample_chain_top.sv
`timescale 1ns/1ns
`include "sample_chain_defs.svh"

module sample_chain_top
    import sample_pkg::*;
    import calib_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,

    input  logic        in_valid,
    input  in_sample_t  in_sample,

    input  logic        cfg_wr,
    input  cfg_write_t  cfg,

    output logic        out_valid,
    output out_sample_t out_sample
);

    logic                             cal_valid;
    in_sample_t                       cal_sample;
    coef_t                            cal_coef;
    logic signed [`SC_OUT_WIDTH-1:0]  goc_data;
    chan_t                            out_chan;

    calib_stage calib_stage_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .cfg_wr     (cfg_wr),
        .cfg        (cfg),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .cal_valid  (cal_valid),
        .cal_sample (cal_sample),
        .cal_coef   (cal_coef)
    );

    gain_offset_clamp gain_offset_clamp_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (cal_valid),
        .in        (cal_sample.data),
        .gain      (cal_coef.gain),
        .offset    (cal_coef.offset),
        .out_valid (out_valid),
        .out       (goc_data)
    );

    // Tag follows the arithmetic pipeline
    tag_delay #(
        .DEPTH (`SC_GOC_LATENCY)
    ) tag_delay_i (
        .clk      (clk),
        .chan_in  (cal_sample.chan),
        .chan_out (out_chan)
    );

    assign out_sample.chan = out_chan;
    assign out_sample.data = goc_data;

endmodule

//--- testbench/sample_chain_tb.sv
`timescale 1ns/1ns
`include "sample_chain_defs.svh"

module sample_chain_tb
    import sample_pkg::*;
    import calib_pkg::*;
();

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 8;
    localparam int LATENCY       = 5;  // in_valid to out_valid
    localparam int IDLE_CYCLES   = 10;
    localparam int UNITY_SAMPLES = 32;
    localparam int CFG_CYCLES    = 3 * `SC_NUM_CHAN;
    localparam int RAND_SAMPLES  = 160;
    localparam int SAT_SAMPLES   = 40;
    localparam int GAP_CYCLES    = 160;
    localparam int RULE_CYCLES   = 5 * `SC_NUM_CHAN;
    localparam int DRAIN_CYCLES  = 10;
    localparam int STIM_CYCLES   = IDLE_CYCLES + UNITY_SAMPLES + CFG_CYCLES + RAND_SAMPLES
                                 + SAT_SAMPLES + GAP_CYCLES + RULE_CYCLES + DRAIN_CYCLES;
    localparam int CYCLE_LIMIT   = RESET_CYCLES + STIM_CYCLES + 100;

    typedef struct packed {
        chan_t                           chan;
        logic signed [`SC_OUT_WIDTH-1:0] data;
        logic [31:0]                     due_cycle;
    } expect_t;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    in_sample_t  in_sample;
    logic        cfg_wr;
    cfg_write_t  cfg;
    logic        out_valid;
    out_sample_t out_sample;

    coef_t       coef_model [`SC_NUM_CHAN];
    expect_t     expected_q [$];
    int          seed = 50744;
    int          cycle_count = 0;

    sample_chain_top dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .cfg_wr     (cfg_wr),
        .cfg        (cfg),
        .out_valid  (out_valid),
        .out_sample (out_sample)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(
        input string              name,
        input logic signed [31:0] actual,
        input logic signed [31:0] expected
    );
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, actual,
                     expected);
            abort_run();
        end
    endtask

    // Saturated floor of (in * gain + offset * 2^radix) / 2^radix
    function automatic logic signed [`SC_OUT_WIDTH-1:0] reference_out(
        input logic signed [`SC_IN_WIDTH-1:0] data,
        input coef_t                          coef
    );
        longint scale;
        longint num;
        longint quot;
        longint out_max;
        scale   = longint'(1) << `SC_GAIN_RADIX;
        out_max = (longint'(1) << (`SC_OUT_WIDTH - 1)) - 1;
        num     = longint'(data) * longint'(coef.gain) + longint'(coef.offset) * scale;
        quot    = num / scale;
        if ((num % scale != 0) && (num < 0)) begin
            quot = quot - 1;  // Division truncates toward zero
        end
        if (quot > out_max) begin
            quot = out_max;
        end else if (quot < -out_max - 1) begin
            quot = -out_max - 1;
        end
        return quot[`SC_OUT_WIDTH-1:0];
    endfunction

    function automatic cfg_write_t make_cfg(input int chan, input int gain, input int offset);
        cfg_write_t wcfg;
        wcfg.chan        = chan[`SC_CHAN_WIDTH-1:0];
        wcfg.coef.gain   = gain[`SC_GAIN_WIDTH-1:0];
        wcfg.coef.offset = offset[`SC_OFFSET_WIDTH-1:0];
        return wcfg;
    endfunction

    // Data magnitude kept below 2^(data_bits-1)
    function automatic in_sample_t random_sample(input int data_bits);
        in_sample_t s;
        int         raw;
        raw    = $random(seed);
        s.chan = raw[`SC_CHAN_WIDTH-1:0];
        raw    = $random(seed) % (1 << (data_bits - 1));
        s.data = raw[`SC_IN_WIDTH-1:0];
        return s;
    endfunction

    task automatic drive_cycle(
        input logic       valid,
        input in_sample_t sample,
        input logic       wr,
        input cfg_write_t wcfg
    );
        expect_t entry;
        @(negedge clk);
        in_valid  = valid;
        in_sample = sample;
        cfg_wr    = wr;
        cfg       = wcfg;
        if (valid) begin
            entry.chan      = sample.chan;
            entry.data      = reference_out(sample.data, coef_model[sample.chan]);
            entry.due_cycle = cycle_count + LATENCY;
            expected_q.push_back(entry);
        end
        // Same-edge write lands after the sample has read the table
        if (wr) begin
            coef_model[wcfg.chan] = wcfg.coef;
        end
    endtask

    task automatic write_coef(input int chan, input int gain, input int offset);
        drive_cycle(1'b0, '0, 1'b1, make_cfg(chan, gain, offset));
    endtask

    initial begin
        in_sample_t s;
        cfg_write_t wcfg;
        int         r;
        in_valid  = 1'b0;
        in_sample = '0;
        cfg_wr    = 1'b0;
        cfg       = '0;
        arst_n    = 1'b0;
        for (int c = 0; c < `SC_NUM_CHAN; c++) begin
            wcfg          = make_cfg(c, 1 << `SC_GAIN_RADIX, 0);
            coef_model[c] = wcfg.coef;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        repeat (IDLE_CYCLES) begin
            drive_cycle(1'b0, '0, 1'b0, '0);
            check_value("out_valid", out_valid, 0);
        end
        for (int i = 0; i < UNITY_SAMPLES; i++) begin
            s      = random_sample(`SC_OUT_WIDTH);  // Fits the output, passes unchanged
            s.chan = chan_t'(i % `SC_NUM_CHAN);
            drive_cycle(1'b1, s, 1'b0, '0);
        end

        write_coef(0, 384, 10);    // 1.5
        write_coef(1, -192, -20);  // -0.75
        write_coef(2, 77, 3);
        write_coef(3, -40, -5);
        for (int i = 0; i < RAND_SAMPLES; i++) begin
            drive_cycle(1'b1, random_sample(9), 1'b0, '0);
        end

        // Saturation
        write_coef(0, 32767, 0);
        write_coef(1, -32768, 0);
        write_coef(2, 4096, 511);
        write_coef(3, -4096, -512);
        for (int i = 0; i < SAT_SAMPLES; i++) begin
            drive_cycle(1'b1, random_sample(`SC_IN_WIDTH), 1'b0, '0);
        end

        for (int c = 0; c < `SC_NUM_CHAN; c++) begin
            write_coef(c, $random(seed) % 1024, $random(seed) % 512);
        end
        for (int i = 0; i < GAP_CYCLES; i++) begin
            r = $random(seed);
            drive_cycle(r[0], random_sample(`SC_IN_WIDTH), 1'b0, '0);
        end

        // Writes between samples of one channel
        for (int c = 0; c < `SC_NUM_CHAN; c++) begin
            s      = random_sample(`SC_OUT_WIDTH);
            s.chan = chan_t'(c);
            drive_cycle(1'b1, s, 1'b0, '0);
            drive_cycle(1'b1, s, 1'b1, make_cfg(c, 100 + 16 * c, 7));
            drive_cycle(1'b1, s, 1'b0, '0);
            drive_cycle(1'b0, s, 1'b1, make_cfg(c, -150, -9));
            drive_cycle(1'b1, s, 1'b0, '0);
        end

        repeat (DRAIN_CYCLES) drive_cycle(1'b0, '0, 1'b0, '0);
        if (expected_q.size() != 0) begin
            $display("%0d expected outputs never appeared", expected_q.size());
            abort_run();
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

    // Outputs are registered, the falling edge sees them settled
    always @(negedge clk) begin
        expect_t entry;
        if (arst_n && out_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("out_valid at %0t ns with no sample in flight", $time);
                abort_run();
            end else begin
                entry = expected_q.pop_front();
                check_value("out_sample.chan", out_sample.chan, entry.chan);
                check_value("out_sample.data", out_sample.data, entry.data);
                check_value("output cycle", cycle_count, entry.due_cycle);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, run did not finish", cycle_count);
            abort_run();
        end
    end

endmodule

//--- sample_chain.f
+incdir+common
common/sample_pkg.sv
common/calib_pkg.sv
source/calib_stage.sv
gain_offset_clamp/gain_offset_clamp.sv
source/tag_delay.sv
source/sample_chain_top.sv
testbench/sample_chain_tb.sv

//--- Makefile
# Verilator build and run for the sample conditioning chain

VERILATOR ?= verilator
TOP       ?= sample_chain_tb
FILELIST  ?= sample_chain.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard common/*.sv common/*.svh source/*.sv gain_offset_clamp/*.sv testbench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
